// File: Makefile
# Verilator build and run for the CSR subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_csr_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
+incdir+logic
logic/csr_pkg.sv
logic/cpu_pkg.sv
logic/csr_if.sv
logic/csr_exec.sv
logic/csr_reg.sv
logic/clint.sv
logic/csr_top.sv
tests/clk_gen.sv
tests/tb_csr_top.sv

// File: logic/clint.sv
`timescale 1ns/100ps
`include "rooth_consts.svh"

module clint (
    input  logic                  clk,
    input  logic                  rst_n,
    input  csr_pkg::trap_kind_e   trap_req_i,
    input  logic                  instr_valid_i,
    input  logic [`CPU_WIDTH-1:0] pc_i,
    input  logic                  irq_i,
    trap_port_if.trap             regs,
    output logic                  busy_o,
    output logic                  redirect_o,
    output logic [`CPU_WIDTH-1:0] redirect_pc_o
);

    csr_pkg::clint_state_e state;
    csr_pkg::clint_state_e state_nxt;
    // Captured at the trigger cycle
    csr_pkg::trap_kind_e   kind_q;
    logic [`CPU_WIDTH-1:0] pc_q;
    logic                  irq_take;
    logic [`CPU_WIDTH-1:0] ms_trap;
    logic [`CPU_WIDTH-1:0] ms_mret;

    // ------------------------------------------------------------------------
    // Trigger detection
    // ------------------------------------------------------------------------
    // Only in a bubble with global and timer enables both set
    assign irq_take = irq_i && !instr_valid_i && !busy_o &&
                      regs.mstatus[`MSTATUS_MIE] && regs.mie[`MIE_MTIE];

    always_ff @(posedge clk) begin
        if (state == csr_pkg::CL_IDLE) begin
            pc_q   <= pc_i;
            kind_q <= irq_take ? csr_pkg::TRAP_IRQ : trap_req_i;
        end
    end

    // ------------------------------------------------------------------------
    // Sequence FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            csr_pkg::CL_IDLE: begin
                if ((trap_req_i == csr_pkg::TRAP_ECALL) || irq_take)
                    state_nxt = csr_pkg::CL_MEPC;
                else if (trap_req_i == csr_pkg::TRAP_MRET)
                    state_nxt = csr_pkg::CL_MRET_MSTATUS;
            end
            csr_pkg::CL_MEPC:         state_nxt = csr_pkg::CL_MCAUSE;
            csr_pkg::CL_MCAUSE:       state_nxt = csr_pkg::CL_MSTATUS;
            csr_pkg::CL_MSTATUS:      state_nxt = csr_pkg::CL_REDIR;
            csr_pkg::CL_MRET_MSTATUS: state_nxt = csr_pkg::CL_MRET_REDIR;
            default:                  state_nxt = csr_pkg::CL_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= csr_pkg::CL_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Trap entry copies MIE into MPIE and clears MIE
    always_comb begin
        ms_trap                = regs.mstatus;
        ms_trap[`MSTATUS_MPIE] = regs.mstatus[`MSTATUS_MIE];
        ms_trap[`MSTATUS_MIE]  = 1'b0;
    end

    // mret restores MIE from MPIE and sets MPIE
    always_comb begin
        ms_mret                = regs.mstatus;
        ms_mret[`MSTATUS_MIE]  = regs.mstatus[`MSTATUS_MPIE];
        ms_mret[`MSTATUS_MPIE] = 1'b1;
    end

    // One client write per state
    always_comb begin
        regs.wr_en   = 1'b0;
        regs.wr_addr = `CSR_MSTATUS;
        regs.wr_data = ms_trap;
        case (state)
            csr_pkg::CL_MEPC: begin
                regs.wr_en   = 1'b1;
                regs.wr_addr = `CSR_MEPC;
                regs.wr_data = pc_q;
            end
            csr_pkg::CL_MCAUSE: begin
                regs.wr_en   = 1'b1;
                regs.wr_addr = `CSR_MCAUSE;
                regs.wr_data = (kind_q == csr_pkg::TRAP_IRQ) ? `MCAUSE_TIMER : `MCAUSE_ECALL;
            end
            csr_pkg::CL_MSTATUS: begin
                regs.wr_en   = 1'b1;
            end
            csr_pkg::CL_MRET_MSTATUS: begin
                regs.wr_en   = 1'b1;
                regs.wr_data = ms_mret;
            end
            default: ;
        endcase
    end

    assign busy_o        = (state != csr_pkg::CL_IDLE);
    assign redirect_o    = (state == csr_pkg::CL_REDIR) || (state == csr_pkg::CL_MRET_REDIR);
    // Trap target vs return address
    assign redirect_pc_o = (state == csr_pkg::CL_MRET_REDIR) ? regs.mepc : regs.mtvec;

    // Core must stall while a sequence runs
    a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
        busy_o |-> !instr_valid_i);

    a_redirect_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_o |=> !redirect_o);

endmodule

// File: logic/cpu_pkg.sv
`include "rooth_consts.svh"

package cpu_pkg;

    // ------------------------------------------------------------------------
    // Instruction word views for the SYSTEM opcode
    // ------------------------------------------------------------------------

    // Zicsr layout where rs1 doubles as uimm for the immediate forms
    typedef struct packed {
        logic [`CSR_ADDR_WIDTH-1:0] addr;
        logic [4:0]                 rs1;
        logic [2:0]                 funct3;
        logic [4:0]                 rd;
        logic [6:0]                 opcode;
    } instr_csr_s;

    // Privileged layout with funct12 picking ecall or mret
    typedef struct packed {
        logic [11:0] funct12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_sys_s;

    // Same 32 bits seen three ways
    typedef union packed {
        logic [`CPU_WIDTH-1:0] raw;
        instr_csr_s            csr;
        instr_sys_s            sys;
    } instr_u;

endpackage

// File: logic/csr_exec.sv
`timescale 1ns/100ps
`include "rooth_consts.svh"

module csr_exec (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid_i,
    input  cpu_pkg::instr_u       instr_i,
    input  logic [`CPU_WIDTH-1:0] rs1_data_i,
    csr_port_if.exec              csr,
    output logic                  rd_we_o,
    output logic [`CPU_WIDTH-1:0] rd_data_o,
    output csr_pkg::trap_kind_e   trap_req_o
);

    logic                  is_system;
    logic                  priv_fields_zero;
    csr_pkg::csr_op_e      op;
    logic [`CPU_WIDTH-1:0] src;
    logic                  src_nonzero;
    logic [`CPU_WIDTH-1:0] new_val;

    // ------------------------------------------------------------------------
    // Zicsr decode
    // ------------------------------------------------------------------------
    assign is_system = instr_valid_i && (instr_i.csr.opcode == `OPC_SYSTEM);

    // funct3[1:0] gives the op and funct3[2] the immediate form
    always_comb begin
        op = csr_pkg::CSR_OP_NONE;
        if (is_system) begin
            case (instr_i.csr.funct3[1:0])
                2'b01:   op = csr_pkg::CSR_OP_WRITE;
                2'b10:   op = csr_pkg::CSR_OP_SET;
                2'b11:   op = csr_pkg::CSR_OP_CLEAR;
                default: op = csr_pkg::CSR_OP_NONE;
            endcase
        end
    end

    // uimm is zero-extended from the rs1 field
    assign src = instr_i.csr.funct3[2] ?
                 {{(`CPU_WIDTH-5){1'b0}}, instr_i.csr.rs1} : rs1_data_i;

    // x0 or uimm 0 means no write for set and clear
    assign src_nonzero = (instr_i.csr.rs1 != 5'd0);

    always_comb begin
        case (op)
            csr_pkg::CSR_OP_WRITE: new_val = src;
            csr_pkg::CSR_OP_SET:   new_val = csr.rd_data | src;
            csr_pkg::CSR_OP_CLEAR: new_val = csr.rd_data & ~src;
            default:               new_val = csr.rd_data;
        endcase
    end

    // Read and write share the instruction's CSR address
    assign csr.rd_addr = instr_i.csr.addr;
    assign csr.wr_addr = instr_i.csr.addr;
    assign csr.wr_data = new_val;
    assign csr.wr_en   = (op == csr_pkg::CSR_OP_WRITE) ||
                         (((op == csr_pkg::CSR_OP_SET) || (op == csr_pkg::CSR_OP_CLEAR)) &&
                          src_nonzero);

    // Old value goes back to rd in the same cycle and the core drops x0
    assign rd_we_o   = (op != csr_pkg::CSR_OP_NONE);
    assign rd_data_o = csr.rd_data;

    // ------------------------------------------------------------------------
    // ecall / mret
    // ------------------------------------------------------------------------
    // rs1, funct3 and rd all zero
    assign priv_fields_zero = (instr_i.raw[19:7] == '0);

    always_comb begin
        trap_req_o = csr_pkg::TRAP_NONE;
        if (is_system && priv_fields_zero) begin
            if (instr_i.sys.funct12 == `FUNCT12_ECALL)
                trap_req_o = csr_pkg::TRAP_ECALL;
            else if (instr_i.sys.funct12 == `FUNCT12_MRET)
                trap_req_o = csr_pkg::TRAP_MRET;
        end
    end

    // A trap request never carries a CSR write along
    a_no_trap_with_write: assert property (@(posedge clk) disable iff (!rst_n)
        !((trap_req_o != csr_pkg::TRAP_NONE) && csr.wr_en));

endmodule

// File: logic/csr_if.sv
`timescale 1ns/100ps
`include "rooth_consts.svh"

// ----------------------------------------------------------------------------
// Core side access into the CSR file
// ----------------------------------------------------------------------------
interface csr_port_if;
    // Read is combinational from rd_addr
    logic [`CSR_ADDR_WIDTH-1:0] rd_addr;
    logic [`CPU_WIDTH-1:0]      rd_data;
    // Write lands on the next rising edge
    logic                       wr_en;
    logic [`CSR_ADDR_WIDTH-1:0] wr_addr;
    logic [`CPU_WIDTH-1:0]      wr_data;

    modport exec (
        output rd_addr, wr_en, wr_addr, wr_data,
        input  rd_data
    );

    modport regs (
        input  rd_addr, wr_en, wr_addr, wr_data,
        output rd_data
    );
endinterface

// ----------------------------------------------------------------------------
// Trap controller write port plus live register levels
// ----------------------------------------------------------------------------
interface trap_port_if;
    // Wins over a core write in the same cycle
    logic                       wr_en;
    logic [`CSR_ADDR_WIDTH-1:0] wr_addr;
    logic [`CPU_WIDTH-1:0]      wr_data;
    // Current register contents
    logic [`CPU_WIDTH-1:0]      mtvec;
    logic [`CPU_WIDTH-1:0]      mepc;
    logic [`CPU_WIDTH-1:0]      mstatus;
    logic [`CPU_WIDTH-1:0]      mie;

    modport trap (
        output wr_en, wr_addr, wr_data,
        input  mtvec, mepc, mstatus, mie
    );

    modport regs (
        input  wr_en, wr_addr, wr_data,
        output mtvec, mepc, mstatus, mie
    );
endinterface

// File: logic/csr_pkg.sv
package csr_pkg;

    // ------------------------------------------------------------------------
    // CSR access and trap handling types
    // ------------------------------------------------------------------------

    // Read-modify-write flavour of a CSR instruction
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'd0,
        CSR_OP_WRITE = 2'd1,
        CSR_OP_SET   = 2'd2,
        CSR_OP_CLEAR = 2'd3
    } csr_op_e;

    // Event the trap controller is working on
    typedef enum logic [1:0] {
        TRAP_NONE  = 2'd0,
        TRAP_ECALL = 2'd1,
        TRAP_IRQ   = 2'd2,
        TRAP_MRET  = 2'd3
    } trap_kind_e;

    // Trap controller sequence with one state per cycle
    typedef enum logic [2:0] {
        CL_IDLE         = 3'd0,
        CL_MEPC         = 3'd1,
        CL_MCAUSE       = 3'd2,
        CL_MSTATUS      = 3'd3,
        CL_REDIR        = 3'd4,
        CL_MRET_MSTATUS = 3'd5,
        CL_MRET_REDIR   = 3'd6
    } clint_state_e;

endpackage

// File: logic/csr_reg.sv
`timescale 1ns/100ps
`include "rooth_consts.svh"

module csr_reg (
    input logic       clk,
    input logic       rst_n,
    csr_port_if.regs  core,
    trap_port_if.regs client
);

    // Free running and read only
    logic [2*`CPU_WIDTH-1:0]    cycle;
    logic [`CPU_WIDTH-1:0]      mtvec;
    logic [`CPU_WIDTH-1:0]      mcause;
    logic [`CPU_WIDTH-1:0]      mepc;
    logic [`CPU_WIDTH-1:0]      mie;
    logic [`CPU_WIDTH-1:0]      mstatus;
    logic [`CPU_WIDTH-1:0]      mscratch;

    // Merged write request
    logic                       wr_en;
    logic [`CSR_ADDR_WIDTH-1:0] wr_addr;
    logic [`CPU_WIDTH-1:0]      wr_data;

    // ------------------------------------------------------------------------
    // Write arbitration with the trap client first
    // ------------------------------------------------------------------------
    assign wr_en   = client.wr_en | core.wr_en;
    assign wr_addr = client.wr_en ? client.wr_addr : core.wr_addr;
    assign wr_data = client.wr_en ? client.wr_data : core.wr_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

    // cycle/cycleh and unknown addresses fall through
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec    <= '0;
            mcause   <= '0;
            mepc     <= '0;
            mie      <= '0;
            mstatus  <= '0;
            mscratch <= '0;
        end else if (wr_en) begin
            case (wr_addr)
                `CSR_MTVEC:    mtvec    <= wr_data;
                `CSR_MCAUSE:   mcause   <= wr_data;
                `CSR_MEPC:     mepc     <= wr_data;
                `CSR_MIE:      mie      <= wr_data;
                `CSR_MSTATUS:  mstatus  <= wr_data;
                `CSR_MSCRATCH: mscratch <= wr_data;
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Core read of registered values only
    // ------------------------------------------------------------------------
    always_comb begin
        case (core.rd_addr)
            `CSR_CYCLE:    core.rd_data = cycle[`CPU_WIDTH-1:0];
            `CSR_CYCLEH:   core.rd_data = cycle[2*`CPU_WIDTH-1:`CPU_WIDTH];
            `CSR_MTVEC:    core.rd_data = mtvec;
            `CSR_MCAUSE:   core.rd_data = mcause;
            `CSR_MEPC:     core.rd_data = mepc;
            `CSR_MIE:      core.rd_data = mie;
            `CSR_MSTATUS:  core.rd_data = mstatus;
            `CSR_MSCRATCH: core.rd_data = mscratch;
            default:       core.rd_data = '0;
        endcase
    end

    // Levels for the trap controller
    assign client.mtvec   = mtvec;
    assign client.mepc    = mepc;
    assign client.mstatus = mstatus;
    assign client.mie     = mie;

    // Counter steps by one each cycle once out of reset
    a_cycle_step: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (cycle == $past(cycle) + 64'd1));

endmodule

// File: logic/csr_top.sv
`timescale 1ns/100ps
`include "rooth_consts.svh"

module csr_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid_i,
    input  logic [`CPU_WIDTH-1:0] instr_i,
    input  logic [`CPU_WIDTH-1:0] pc_i,
    input  logic [`CPU_WIDTH-1:0] rs1_data_i,
    input  logic                  irq_i,
    output logic                  rd_we_o,
    output logic [`CPU_WIDTH-1:0] rd_data_o,
    output logic                  redirect_o,
    output logic [`CPU_WIDTH-1:0] redirect_pc_o,
    output logic                  busy_o
);

    // ecall / mret from decode to the trap controller
    csr_pkg::trap_kind_e trap_req;

    csr_port_if  u_csr_port ();
    trap_port_if u_trap_port ();

    csr_exec u_csr_exec (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .csr           (u_csr_port.exec),
        .rd_we_o       (rd_we_o),
        .rd_data_o     (rd_data_o),
        .trap_req_o    (trap_req)
    );

    csr_reg u_csr_reg (
        .clk    (clk),
        .rst_n  (rst_n),
        .core   (u_csr_port.regs),
        .client (u_trap_port.regs)
    );

    clint u_clint (
        .clk           (clk),
        .rst_n         (rst_n),
        .trap_req_i    (trap_req),
        .instr_valid_i (instr_valid_i),
        .pc_i          (pc_i),
        .irq_i         (irq_i),
        .regs          (u_trap_port.trap),
        .busy_o        (busy_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

// File: logic/rooth_consts.svh
`ifndef ROOTH_CONSTS_SVH
`define ROOTH_CONSTS_SVH

// Datapath and CSR address widths
`define CPU_WIDTH       32
`define CSR_ADDR_WIDTH  12

// Machine-mode CSR map
`define CSR_CYCLE       12'hC00
`define CSR_CYCLEH      12'hC80
`define CSR_MSTATUS     12'h300
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342

// Bit positions inside mstatus and mie
`define MSTATUS_MIE     3
`define MSTATUS_MPIE    7
`define MIE_MTIE        7

// mcause values with the interrupt flag in the MSB
`define MCAUSE_ECALL    32'd11
`define MCAUSE_TIMER    32'h8000_0007

// SYSTEM opcode and privileged funct12 codes
`define OPC_SYSTEM      7'b1110011
`define FUNCT12_ECALL   12'h000
`define FUNCT12_MRET    12'h302

`endif

// File: tests/clk_gen.sv
`timescale 1ns/100ps

module clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    // Free running clock starting low at time zero
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release just after an edge so no flop sees it on the edge itself
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

// File: tests/tb_csr_top.sv
`timescale 1ns/100ps
`include "rooth_consts.svh"

module tb_csr_top;

    localparam logic [2:0]  F3_RW  = 3'b001;
    localparam logic [2:0]  F3_RS  = 3'b010;
    localparam logic [2:0]  F3_RC  = 3'b011;
    localparam logic [2:0]  F3_RWI = 3'b101;
    localparam logic [2:0]  F3_RSI = 3'b110;
    localparam logic [2:0]  F3_RCI = 3'b111;
    localparam logic [31:0] ECALL_WORD = 32'h0000_0073;
    localparam logic [31:0] MRET_WORD  = 32'h3020_0073;
    localparam logic [11:0] NO_CSR     = 12'h7C0;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic        irq;
    logic        rd_we_o;
    logic [31:0] rd_data_o;
    logic        redirect_o;
    logic [31:0] redirect_pc_o;
    logic        busy_o;

    // Reference CSR state
    logic [63:0] m_cycle;
    logic [31:0] m_mtvec;
    logic [31:0] m_mcause;
    logic [31:0] m_mepc;
    logic [31:0] m_mie;
    logic [31:0] m_mstatus;
    logic [31:0] m_mscratch;
    logic [31:0] m_target;
    logic [2:0]  m_busy;
    // Reference decode of the current input
    logic        m_sys;
    logic        m_csr_op;
    logic        m_wr;
    logic        m_ecall;
    logic        m_mret;
    logic        m_irq;
    logic [2:0]  m_f3;
    logic [31:0] m_src;
    logic [31:0] m_new;
    logic [31:0] exp_rd;

    clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(8)) u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    csr_top u_csr_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_i          (pc),
        .rs1_data_i    (rs1_data),
        .irq_i         (irq),
        .rd_we_o       (rd_we_o),
        .rd_data_o     (rd_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .busy_o        (busy_o)
    );

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] status_after_trap(input logic [31:0] s);
        logic [31:0] r;
        r = s;
        r[`MSTATUS_MPIE] = s[`MSTATUS_MIE];
        r[`MSTATUS_MIE]  = 1'b0;
        return r;
    endfunction

    function automatic logic [31:0] status_after_mret(input logic [31:0] s);
        logic [31:0] r;
        r = s;
        r[`MSTATUS_MIE]  = s[`MSTATUS_MPIE];
        r[`MSTATUS_MPIE] = 1'b1;
        return r;
    endfunction

    // Zicsr fields straight from the ISA encoding
    assign m_sys    = instr_valid && (instr[6:0] == 7'b1110011);
    assign m_f3     = instr[14:12];
    assign m_csr_op = m_sys && (m_f3[1:0] != 2'b00);
    assign m_src    = m_f3[2] ? {27'd0, instr[19:15]} : rs1_data;
    // Set/clear with x0 or uimm 0 writes nothing
    assign m_wr     = m_csr_op && ((m_f3[1:0] == 2'b01) || (instr[19:15] != 5'd0));
    assign m_ecall  = instr_valid && (instr == ECALL_WORD);
    assign m_mret   = instr_valid && (instr == MRET_WORD);
    // Interrupt only in an idle bubble with both enables set
    assign m_irq    = irq && !instr_valid && (m_busy == 3'd0) &&
                      m_mstatus[`MSTATUS_MIE] && m_mie[`MIE_MTIE];

    always_comb begin
        case (instr[31:20])
            `CSR_CYCLE:    exp_rd = m_cycle[31:0];
            `CSR_CYCLEH:   exp_rd = m_cycle[63:32];
            `CSR_MTVEC:    exp_rd = m_mtvec;
            `CSR_MCAUSE:   exp_rd = m_mcause;
            `CSR_MEPC:     exp_rd = m_mepc;
            `CSR_MIE:      exp_rd = m_mie;
            `CSR_MSTATUS:  exp_rd = m_mstatus;
            `CSR_MSCRATCH: exp_rd = m_mscratch;
            default:       exp_rd = 32'd0;
        endcase
        case (m_f3[1:0])
            2'b01:   m_new = m_src;
            2'b10:   m_new = exp_rd | m_src;
            default: m_new = exp_rd & ~m_src;
        endcase
    end

    // Trap side effects land at once; no read can see the gap while busy
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_cycle <= 64'd0;
            m_mtvec <= 32'd0;
            m_mcause <= 32'd0;
            m_mepc <= 32'd0;
            m_mie <= 32'd0;
            m_mstatus <= 32'd0;
            m_mscratch <= 32'd0;
            m_target <= 32'd0;
            m_busy <= 3'd0;
        end else begin
            m_cycle <= m_cycle + 64'd1;
            if (m_busy != 3'd0)
                m_busy <= m_busy - 3'd1;
            if (m_wr) begin
                case (instr[31:20])
                    `CSR_MTVEC:    m_mtvec <= m_new;
                    `CSR_MCAUSE:   m_mcause <= m_new;
                    `CSR_MEPC:     m_mepc <= m_new;
                    `CSR_MIE:      m_mie <= m_new;
                    `CSR_MSTATUS:  m_mstatus <= m_new;
                    `CSR_MSCRATCH: m_mscratch <= m_new;
                    default: ;
                endcase
            end
            if (m_ecall || m_irq) begin
                m_mepc    <= pc;
                m_mcause  <= m_irq ? `MCAUSE_TIMER : `MCAUSE_ECALL;
                m_mstatus <= status_after_trap(m_mstatus);
                m_target  <= m_mtvec;
                m_busy    <= 3'd4;
            end else if (m_mret) begin
                m_mstatus <= status_after_mret(m_mstatus);
                m_target  <= m_mepc;
                m_busy    <= 3'd2;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first failure");
    endtask

    a_rd_we: assert property (@(posedge clk) disable iff (!rst_n) rd_we_o == m_csr_op)
        else stop_with_failure($sformatf("ERROR at %0t ns: rd_we_o is %0b, expected %0b",
                                         $time, $sampled(rd_we_o), $sampled(m_csr_op)));

    // Old CSR value comes back in the instruction's own cycle
    a_rd_data: assert property (@(posedge clk) disable iff (!rst_n)
        m_csr_op |-> rd_data_o == exp_rd)
        else stop_with_failure($sformatf("ERROR at %0t ns: csr %h read %h, expected %h",
                                         $time, $sampled(instr[31:20]),
                                         $sampled(rd_data_o), $sampled(exp_rd)));

    // Four busy cycles for a trap and two for mret
    a_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy_o == (m_busy != 3'd0))
        else stop_with_failure($sformatf("ERROR at %0t ns: busy_o is %0b, expected %0b",
                                         $time, $sampled(busy_o), $sampled(m_busy != 3'd0)));

    // Redirect in the last busy cycle only
    a_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_o == (m_busy == 3'd1))
        else stop_with_failure($sformatf("ERROR at %0t ns: redirect_o is %0b, expected %0b",
                                         $time, $sampled(redirect_o),
                                         $sampled(m_busy == 3'd1)));

    a_redirect_pc: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_o |-> redirect_pc_o == m_target)
        else stop_with_failure($sformatf("ERROR at %0t ns: redirect_pc_o %h, expected %h",
                                         $time, $sampled(redirect_pc_o),
                                         $sampled(m_target)));

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) step_cycle();
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (!rst_n && n < 20) begin
            step_cycle();
            n++;
        end
        if (!rst_n)
            stop_with_failure("Reset was never released within 20 cycles");
        else
            step_cycle();
    endtask

    task automatic exec_csr(input logic [11:0] addr, input logic [2:0] f3,
                            input logic [4:0] rs1, input logic [31:0] rs1_val);
        instr_valid = 1'b1;
        instr       = {addr, rs1, f3, 5'd1, 7'b1110011};
        rs1_data    = rs1_val;
        step_cycle();
        instr_valid = 1'b0;
        instr       = 32'd0;
        rs1_data    = 32'd0;
    endtask

    // Side-effect free read through csrrs with x0
    task automatic read_csr(input logic [11:0] addr);
        exec_csr(addr, F3_RS, 5'd0, 32'd0);
    endtask

    task automatic exec_system(input logic [31:0] word, input logic [31:0] pc_val);
        instr_valid = 1'b1;
        instr       = word;
        pc          = pc_val;
        step_cycle();
        instr_valid = 1'b0;
        instr       = 32'd0;
    endtask

    task automatic wait_redirect(input int limit);
        int n;
        n = 0;
        while (!redirect_o && n < limit) begin
            step_cycle();
            n++;
        end
        if (!redirect_o)
            stop_with_failure($sformatf("Timed out: no redirect within %0d cycles", limit));
        else
            step_cycle();
    endtask

    initial begin
        logic [31:0] rnd;
        int          i;
        instr_valid = 1'b0;
        instr       = 32'd0;
        pc          = 32'd0;
        rs1_data    = 32'd0;
        irq         = 1'b0;
        void'($urandom(32'h7b2f0cbe));
        wait_reset_release();

        // csrrw returns the old value and an x0 read leaves it alone
        exec_csr(`CSR_MSCRATCH, F3_RW, 5'd5, $urandom());
        read_csr(`CSR_MSCRATCH);
        read_csr(`CSR_MSCRATCH);
        rnd = $urandom();
        exec_csr(`CSR_MTVEC, F3_RW, 5'd6, rnd & ~32'd3);
        read_csr(`CSR_MTVEC);

        // Masked set and clear from register and immediate sources
        for (i = 0; i < 8; i++) begin
            exec_csr(`CSR_MSCRATCH, F3_RS, 5'd7, $urandom());
            exec_csr(`CSR_MSCRATCH, F3_RC, 5'd8, $urandom());
            rnd = $urandom();
            exec_csr(`CSR_MSCRATCH, F3_RSI, rnd[4:0], 32'd0);
            exec_csr(`CSR_MSCRATCH, F3_RCI, rnd[9:5], 32'd0);
            read_csr(`CSR_MSCRATCH);
        end
        exec_csr(`CSR_MSCRATCH, F3_RWI, 5'd0, 32'd0);
        read_csr(`CSR_MSCRATCH);

        // Unknown address reads zero and cycle ignores writes
        exec_csr(NO_CSR, F3_RW, 5'd9, $urandom());
        read_csr(NO_CSR);
        exec_csr(`CSR_CYCLE, F3_RW, 5'd9, $urandom());
        read_csr(`CSR_CYCLE);

        // Counter reads a random gap apart
        read_csr(`CSR_CYCLE);
        idle_cycles($urandom_range(20, 2));
        read_csr(`CSR_CYCLE);
        read_csr(`CSR_CYCLEH);

        // ecall with MIE set and mret back
        exec_csr(`CSR_MSTATUS, F3_RSI, 5'b01000, 32'd0);
        rnd = $urandom();
        exec_system(ECALL_WORD, rnd & ~32'd3);
        wait_redirect(10);
        read_csr(`CSR_MEPC);
        read_csr(`CSR_MCAUSE);
        read_csr(`CSR_MSTATUS);
        exec_system(MRET_WORD, $urandom());
        wait_redirect(10);
        read_csr(`CSR_MSTATUS);

        // irq masked by mie.MTIE
        exec_csr(`CSR_MIE, F3_RW, 5'd10, 32'd0);
        irq = 1'b1;
        idle_cycles(5);
        irq = 1'b0;
        // irq masked by mstatus.MIE
        exec_csr(`CSR_MIE, F3_RW, 5'd10, 32'd1 << `MIE_MTIE);
        exec_csr(`CSR_MSTATUS, F3_RCI, 5'b01000, 32'd0);
        irq = 1'b1;
        idle_cycles(5);
        irq = 1'b0;

        // Both enables set so the next bubble traps
        exec_csr(`CSR_MSTATUS, F3_RSI, 5'b01000, 32'd0);
        rnd = $urandom();
        pc  = rnd & ~32'd3;
        irq = 1'b1;
        step_cycle();
        irq = 1'b0;
        wait_redirect(10);
        read_csr(`CSR_MEPC);
        read_csr(`CSR_MCAUSE);
        read_csr(`CSR_MSTATUS);
        exec_system(MRET_WORD, $urandom());
        wait_redirect(10);
        read_csr(`CSR_MSTATUS);

        idle_cycles(3);
        $display("Done: no errors");
        $finish;
    end

endmodule
